// File: include/swu_defs.svh
`ifndef SWU_DEFS_SVH
`define SWU_DEFS_SVH

//////////////////////////////////////////////////
// stream word geometry
//////////////////////////////////////////////////

// lanes per channel-group word and bits per lane
`define SWU_SIMD        4
`define SWU_PREC        8
`define SWU_WORD_W      32
// channel groups that make up one pixel
`define SWU_EFF_CH      2

//////////////////////////////////////////////////
// window geometry
//////////////////////////////////////////////////

`define SWU_IFM_DIM     5
`define SWU_K           3
`define SWU_OFM_DIM     3
// output columns served side by side in one beat
`define SWU_MMV_OUT     3
`define SWU_FRAME_WORDS 50
`define SWU_ADDR_W      6

`endif

// File: hw/swu_pkg.sv
`include "swu_defs.svh"

package swu_pkg;

   // one channel-group word of SIMD lanes
   typedef logic [`SWU_WORD_W-1:0] word_t;

   typedef logic [`SWU_ADDR_W-1:0] buf_addr_t;

   // write port broadcast to every buffer copy
   typedef struct packed {
      logic      en;
      buf_addr_t addr;
      word_t     data;
   } wr_port_t;

   // window position, outermost field first
   typedef struct packed {
      logic [$clog2(`SWU_OFM_DIM)-1:0]                  out_row;
      logic [$clog2(`SWU_OFM_DIM / `SWU_MMV_OUT + 1)-1:0] col_grp;
      logic [$clog2(`SWU_K)-1:0]                        k_row;
      logic [$clog2(`SWU_K)-1:0]                        k_col;
      logic [$clog2(`SWU_EFF_CH)-1:0]                   ch_grp;
   } win_pos_t;

   // lane 0 sits in the low word
   typedef word_t [`SWU_MMV_OUT-1:0] out_beat_t;

endpackage

// File: hw/swu_input_ctrl.sv
`timescale 1ns/10ps
`include "swu_defs.svh"

module swu_input_ctrl (
   input  logic               clk,
   input  logic               resetn,
   input  logic               in_valid_i,
   input  swu_pkg::word_t     in_data_i,
   input  logic               frame_done_i,
   output logic               in_ready_o,
   output swu_pkg::wr_port_t  wr_o,
   output logic               frame_loaded_o
);

   swu_pkg::buf_addr_t wr_cnt;
   logic               frame_loaded;
   logic               accept;

   // loading and reading alternate, the buffer holds a whole frame
   assign in_ready_o = ~frame_loaded;
   assign accept     = in_valid_i & in_ready_o;

   // write lands in the accept cycle
   assign wr_o.en   = accept;
   assign wr_o.addr = wr_cnt;
   assign wr_o.data = in_data_i;

   assign frame_loaded_o = frame_loaded;

   always_ff @(posedge clk) begin
      if (!resetn) begin
         wr_cnt       <= '0;
         frame_loaded <= 1'b0;
      end else begin
         if (accept) begin
            if (wr_cnt == swu_pkg::buf_addr_t'(`SWU_FRAME_WORDS - 1)) begin
               wr_cnt       <= '0;
               frame_loaded <= 1'b1;
            end else begin
               wr_cnt <= wr_cnt + 1'b1;
            end
         end
         // every read of the frame is issued, buffer may be refilled
         if (frame_done_i) begin
            frame_loaded <= 1'b0;
         end
      end
   end

endmodule

// File: hw/swu_window_seq.sv
`timescale 1ns/10ps
`include "swu_defs.svh"

module swu_window_seq (
   input  logic              clk,
   input  logic              resetn,
   input  logic              issue_i,
   output swu_pkg::win_pos_t pos_o,
   output logic              frame_done_o
);

   localparam int COL_GRPS = `SWU_OFM_DIM / `SWU_MMV_OUT;

   swu_pkg::win_pos_t pos_q;
   logic              last_ch;
   logic              last_kc;
   logic              last_kr;
   logic              last_cg;
   logic              last_row;

   assign last_ch  = (pos_q.ch_grp  == (`SWU_EFF_CH - 1));
   assign last_kc  = (pos_q.k_col   == (`SWU_K - 1));
   assign last_kr  = (pos_q.k_row   == (`SWU_K - 1));
   assign last_cg  = (pos_q.col_grp == (COL_GRPS - 1));
   assign last_row = (pos_q.out_row == (`SWU_OFM_DIM - 1));

   assign pos_o = pos_q;

   // final window of the frame goes out on this issue
   assign frame_done_o = issue_i & last_ch & last_kc & last_kr & last_cg & last_row;

   //////////////////////////////////////////////////
   // nested walk: channel, kernel col, kernel row,
   // column group, output row
   //////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!resetn) begin
         pos_q <= '0;
      end else if (issue_i) begin
         if (!last_ch) begin
            pos_q.ch_grp <= pos_q.ch_grp + 1'b1;
         end else begin
            pos_q.ch_grp <= '0;
            if (!last_kc) begin
               pos_q.k_col <= pos_q.k_col + 1'b1;
            end else begin
               pos_q.k_col <= '0;
               if (!last_kr) begin
                  pos_q.k_row <= pos_q.k_row + 1'b1;
               end else begin
                  pos_q.k_row <= '0;
                  if (!last_cg) begin
                     pos_q.col_grp <= pos_q.col_grp + 1'b1;
                  end else begin
                     pos_q.col_grp <= '0;
                     // wraps to zero after the last row
                     if (!last_row) begin
                        pos_q.out_row <= pos_q.out_row + 1'b1;
                     end else begin
                        pos_q.out_row <= '0;
                     end
                  end
               end
            end
         end
      end
   end

endmodule

// File: hw/swu_lane_buffer.sv
`timescale 1ns/10ps
`include "swu_defs.svh"

module swu_lane_buffer #(
   parameter int LANE = 0
) (
   input  logic              clk,
   input  logic              resetn,
   input  swu_pkg::wr_port_t wr_i,
   input  swu_pkg::win_pos_t pos_i,
   input  logic              issue_i,
   input  logic              advance_i,
   output swu_pkg::word_t    data_o
);

   swu_pkg::word_t     mem [`SWU_FRAME_WORDS];
   swu_pkg::word_t     rd_word;
   swu_pkg::buf_addr_t rd_addr;
   int unsigned        pix_row;
   int unsigned        pix_col;

   // input pixel seen by this output column
   always_comb begin
      pix_row = pos_i.out_row + pos_i.k_row;
      pix_col = pos_i.col_grp * `SWU_MMV_OUT + LANE + pos_i.k_col;
      rd_addr = swu_pkg::buf_addr_t'((pix_row * `SWU_IFM_DIM + pix_col) * `SWU_EFF_CH
                                     + pos_i.ch_grp);
   end

   always_ff @(posedge clk) begin
      if (wr_i.en) begin
         mem[wr_i.addr] <= wr_i.data;
      end
      // read stage
      if (issue_i) begin
         rd_word <= mem[rd_addr];
      end
   end

   // output register, held under back-pressure
   always_ff @(posedge clk) begin
      if (!resetn) begin
         data_o <= '0;
      end else if (advance_i) begin
         data_o <= rd_word;
      end
   end

endmodule

// File: hw/swu_output_stage.sv
`timescale 1ns/10ps

module swu_output_stage (
   input  logic clk,
   input  logic resetn,
   input  logic frame_loaded_i,
   input  logic out_ready_i,
   output logic issue_o,
   output logic advance_o,
   output logic out_valid_o
);

   logic rd_valid;
   logic out_valid;

   // output register may take a new word
   assign advance_o = out_ready_i | ~out_valid;

   // new position enters the read stage when that stage frees up
   assign issue_o = frame_loaded_i & (~rd_valid | advance_o);

   assign out_valid_o = out_valid;

   //////////////////////////////////////////////////
   // two-stage valid pipeline
   //////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!resetn) begin
         rd_valid <= 1'b0;
      end else if (advance_o | ~rd_valid) begin
         rd_valid <= issue_o;
      end
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         out_valid <= 1'b0;
      end else if (advance_o) begin
         out_valid <= rd_valid;
      end
   end

endmodule

// File: hw/swu_top.sv
`timescale 1ns/10ps
`include "swu_defs.svh"

module swu_top (
   input  logic               clk,
   input  logic               resetn,
   input  logic               in_valid_i,
   input  swu_pkg::word_t     in_data_i,
   input  logic               out_ready_i,
   output logic               in_ready_o,
   output logic               out_valid_o,
   output swu_pkg::out_beat_t out_data_o
);

   swu_pkg::wr_port_t wr;
   swu_pkg::win_pos_t pos;
   logic              frame_loaded;
   logic              frame_done;
   logic              issue;
   logic              advance;

   swu_input_ctrl u_input_ctrl (
      .clk            (clk),
      .resetn         (resetn),
      .in_valid_i     (in_valid_i),
      .in_data_i      (in_data_i),
      .frame_done_i   (frame_done),
      .in_ready_o     (in_ready_o),
      .wr_o           (wr),
      .frame_loaded_o (frame_loaded)
   );

   swu_window_seq u_window_seq (
      .clk          (clk),
      .resetn       (resetn),
      .issue_i      (issue),
      .pos_o        (pos),
      .frame_done_o (frame_done)
   );

   swu_output_stage u_output_stage (
      .clk            (clk),
      .resetn         (resetn),
      .frame_loaded_i (frame_loaded),
      .out_ready_i    (out_ready_i),
      .issue_o        (issue),
      .advance_o      (advance),
      .out_valid_o    (out_valid_o)
   );

   // one buffer copy per output column of the beat
   for (genvar i = 0; i < `SWU_MMV_OUT; i++) begin : g_lane
      swu_lane_buffer #(
         .LANE (i)
      ) u_lane_buffer (
         .clk       (clk),
         .resetn    (resetn),
         .wr_i      (wr),
         .pos_i     (pos),
         .issue_i   (issue),
         .advance_i (advance),
         .data_o    (out_data_o[i])
      );
   end

endmodule

// File: verification/tb_swu_top.sv
`timescale 1ns/10ps
`include "swu_defs.svh"

module tb_swu_top;

   localparam int COL_GRPS = `SWU_OFM_DIM / `SWU_MMV_OUT;
   localparam int BEATS    = `SWU_OFM_DIM * COL_GRPS * `SWU_K * `SWU_K * `SWU_EFF_CH;

   logic               clk;
   logic               resetn;
   logic               in_valid_i;
   swu_pkg::word_t     in_data_i;
   logic               out_ready_i;
   logic               in_ready_o;
   logic               out_valid_o;
   swu_pkg::out_beat_t out_data_o;

   // entry 0 is the word count, the frame follows
   swu_pkg::word_t     file_words [0:`SWU_FRAME_WORDS];
   logic [31:0]        lfsr;
   int                 fed;
   int                 feed_target;
   logic               rand_gaps;
   logic               rand_ready;
   logic               took;
   int                 acc_total;
   int                 beats;
   int                 data_errs;
   int                 proto_errs;
   logic               held;
   swu_pkg::out_beat_t held_data;
   swu_pkg::word_t     exp_word;
   string              test_name;
   logic               ok;

   swu_top u_swu_top (
      .clk         (clk),
      .resetn      (resetn),
      .in_valid_i  (in_valid_i),
      .in_data_i   (in_data_i),
      .out_ready_i (out_ready_i),
      .in_ready_o  (in_ready_o),
      .out_valid_o (out_valid_o),
      .out_data_o  (out_data_o)
   );

   always #5 clk = ~clk;

   // taps 32, 22, 2, 1
   function automatic logic rand_bit();
      logic fb;
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      return fb;
   endfunction

   // input word seen by one lane of one beat, odd frames carry inverted words
   function automatic swu_pkg::word_t expected_word(int beat, int lane);
      int b;
      int ch;
      int kc;
      int kr;
      int cg;
      int row;
      int idx;
      b   = beat % BEATS;
      ch  = b % `SWU_EFF_CH;
      kc  = (b / `SWU_EFF_CH) % `SWU_K;
      kr  = (b / (`SWU_EFF_CH * `SWU_K)) % `SWU_K;
      cg  = (b / (`SWU_EFF_CH * `SWU_K * `SWU_K)) % COL_GRPS;
      row = b / (`SWU_EFF_CH * `SWU_K * `SWU_K * COL_GRPS);
      idx = ((row + kr) * `SWU_IFM_DIM + cg * `SWU_MMV_OUT + lane + kc) * `SWU_EFF_CH + ch;
      expected_word = file_words[1 + idx];
      if ((beat / BEATS) % 2 == 1) begin
         expected_word = ~expected_word;
      end
   endfunction

   task automatic wait_for_beats(input int target, input int limit, output logic done);
      int cycles;
      cycles = 0;
      while (beats < target && cycles < limit) begin
         @(posedge clk);
         cycles++;
      end
      done = (beats >= target);
      if (!done) begin
         $display("timeout after %0d cycles, only %0d of %0d beats seen", limit, beats, target);
      end
   endtask

   //////////////////////////////////////////////////
   // input driver, 1 ns after the rising edge
   //////////////////////////////////////////////////
   always @(posedge clk) begin
      took = in_valid_i & in_ready_o;
      #1;
      if (took) begin
         fed++;
      end
      in_valid_i  = (fed < feed_target) && (!rand_gaps || rand_bit());
      in_data_i   = file_words[1 + fed % `SWU_FRAME_WORDS]
                    ^ {`SWU_WORD_W{fed >= `SWU_FRAME_WORDS}};
      out_ready_i = rand_ready ? rand_bit() : 1'b1;
   end

   //////////////////////////////////////////////////
   // output monitor
   //////////////////////////////////////////////////
   always @(posedge clk) begin
      if (resetn) begin
         if (held) begin
            assert (out_valid_o && out_data_o == held_data) else begin
               $display("output beat changed while stalled at beat %0d", beats);
               proto_errs++;
            end
         end
         // no reload while the loaded frame still has reads to issue
         if (acc_total > 0 && acc_total % `SWU_FRAME_WORDS == 0) begin
            assert (!in_ready_o || beats >= BEATS * (acc_total / `SWU_FRAME_WORDS) - 2) else begin
               $display("input ready while frame still being read, beat %0d", beats);
               proto_errs++;
            end
         end
         if (out_valid_o && out_ready_i) begin
            assert (beats < BEATS * (acc_total / `SWU_FRAME_WORDS)) else begin
               $display("extra beat %0d appeared without a loaded frame", beats);
               proto_errs++;
            end
            for (int lane = 0; lane < `SWU_MMV_OUT; lane++) begin
               exp_word = expected_word(beats, lane);
               assert (out_data_o[lane] == exp_word) else begin
                  $display("ERROR %s beat %0d lane %0d expected %h actual %h",
                           test_name, beats, lane, exp_word, out_data_o[lane]);
                  data_errs++;
               end
            end
            beats++;
         end
         if (in_valid_i && in_ready_o) begin
            acc_total++;
         end
      end
      held      = resetn && out_valid_o && !out_ready_i;
      held_data = out_data_o;
   end

   initial begin
      clk         = 1'b0;
      resetn      = 1'b0;
      in_valid_i  = 1'b0;
      in_data_i   = '0;
      out_ready_i = 1'b0;
      lfsr        = 32'hf2b4;
      fed         = 0;
      feed_target = 0;
      rand_gaps   = 1'b0;
      rand_ready  = 1'b0;
      acc_total   = 0;
      beats       = 0;
      data_errs   = 0;
      proto_errs  = 0;
      held        = 1'b0;
      test_name   = "reset";
      $readmemh("verification/swu_input.txt", file_words);
      assert (file_words[0] == `SWU_FRAME_WORDS) else begin
         $display("data file holds a frame of %0d words instead of %0d",
                  file_words[0], `SWU_FRAME_WORDS);
         proto_errs++;
      end
      repeat (10) @(posedge clk);
      #1 resetn = 1'b1;
      @(posedge clk);
      #2;
      assert (!out_valid_o && in_ready_o) else begin
         $display("wrong state after reset, valid %b ready %b", out_valid_o, in_ready_o);
         proto_errs++;
      end
      // frame 1, steady stream and output always ready
      test_name   = "window_order";
      feed_target = `SWU_FRAME_WORDS;
      wait_for_beats(BEATS, 1000, ok);
      if (ok) begin
         // frame 2, inverted words with input gaps and output stalls
         test_name   = "restart_backpressure";
         rand_gaps   = 1'b1;
         rand_ready  = 1'b1;
         feed_target = 2 * `SWU_FRAME_WORDS;
         wait_for_beats(2 * BEATS, 4000, ok);
      end
      if (ok) begin
         rand_ready = 1'b0;
         repeat (20) @(posedge clk);
         assert (beats == 2 * BEATS && !out_valid_o) else begin
            $display("beats kept coming after the second frame, %0d seen", beats);
            proto_errs++;
         end
      end
      $display("data errors %0d, protocol errors %0d, timeout %0d",
               data_errs, proto_errs, !ok);
      if (!ok || data_errs != 0 || proto_errs != 0) begin
         $display("test failed");
      end else begin
         $display("test passed");
      end
      $finish;
   end

endmodule

// File: verification/swu_input.txt
// first line: number of words in the frame, hex
// then one 32-bit word per line in load order, lane 0 in the low byte
32
03020100
07060504
0b0a0908
0f0e0d0c
13121110
17161514
1b1a1918
1f1e1d1c
23222120
27262524
2b2a2928
2f2e2d2c
33323130
37363534
3b3a3938
3f3e3d3c
43424140
47464544
4b4a4948
4f4e4d4c
53525150
57565554
5b5a5958
5f5e5d5c
63626160
67666564
6b6a6968
6f6e6d6c
73727170
77767574
7b7a7978
7f7e7d7c
83828180
87868584
8b8a8988
8f8e8d8c
93929190
97969594
9b9a9998
9f9e9d9c
a3a2a1a0
a7a6a5a4
abaaa9a8
afaeadac
b3b2b1b0
b7b6b5b4
bbbab9b8
bfbebdbc
c3c2c1c0
c7c6c5c4

// File: swu.f
+incdir+include
hw/swu_pkg.sv
hw/swu_input_ctrl.sv
hw/swu_window_seq.sv
hw/swu_lane_buffer.sv
hw/swu_output_stage.sv
hw/swu_top.sv
verification/tb_swu_top.sv

// File: Bender.yml
package:
  name: swu

export_include_dirs:
  - include

sources:
  - files:
      - hw/swu_pkg.sv
      - hw/swu_input_ctrl.sv
      - hw/swu_window_seq.sv
      - hw/swu_lane_buffer.sv
      - hw/swu_output_stage.sv
      - hw/swu_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/tb_swu_top.sv
